//--- verilog/regReadPkg.sv
// Register-read stage package with widths, counts and ready-table reset pattern
package regReadPkg;

  // ******************************
  // Lanes and checkpoints
  // ******************************

  localparam int NumLanes = 2;  // Issue and writeback lanes
  localparam int NumCkpts = 4;  // Also the mask width
  localparam int CkptIdW = 2;

  // ******************************
  // Physical register file
  // ******************************

  localparam int PhysRegs = 32;
  localparam int PhysTagW = 5;
  localparam int DataW = 32;

  // Architectural mapping after reset points at registers 0 to 7
  localparam int ArchRegs = 8;

  // ******************************
  // Instruction payload
  // ******************************

  localparam int PayloadW = 16;  // Opcode, immediate and the rest

  // ******************************
  // Reset constants
  // ******************************

  // Ready table contents after reset or an exception
  localparam logic [PhysRegs-1:0] ReadyInit = {
    {(PhysRegs - ArchRegs){1'b0}},
    {ArchRegs{1'b1}}
  };

endpackage

//--- verilog/issueLaneIf.sv
// Issued instruction bundle passed from the stage top to one operand lane
`timescale 1ns/1ps

interface issueLaneIf;
  import regReadPkg::*;

  logic                valid;
  logic [PhysTagW-1:0] src1Tag;
  logic [PhysTagW-1:0] src2Tag;
  logic [NumCkpts-1:0] ckptMask;  // Branches this instruction depends on
  logic [PayloadW-1:0] payload;   // Carried to the FU untouched

  modport issuer (
    output valid,
    output src1Tag,
    output src2Tag,
    output ckptMask,
    output payload
  );

  modport lane (
    input valid,
    input src1Tag,
    input src2Tag,
    input ckptMask,
    input payload
  );

endinterface

//--- verilog/physRegFile.sv
// Physical register file with four combinational reads and two clocked writes
`timescale 1ns/1ps

module physRegFile (
  input  logic clk,
  input  logic recover_i,
  input  logic [2*regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] rdTag_i,
  output logic [2*regReadPkg::NumLanes-1:0][regReadPkg::DataW-1:0]    rdData_o,
  input  logic [regReadPkg::NumLanes-1:0]                            wrEn_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0]   wrTag_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::DataW-1:0]      wrData_i
);
  import regReadPkg::*;

  logic [DataW-1:0] regArray [PhysRegs];
  logic [NumLanes-1:0] wrGated;

  // ******************************
  // Read ports
  // ******************************

  // Old contents only since operand lanes bypass same-cycle writes
  always_comb begin
    for (int p = 0; p < 2*NumLanes; p++) begin
      rdData_o[p] = regArray[rdTag_i[p]];
    end
  end

  // ******************************
  // Write ports
  // ******************************

  // No updates while the pipeline recovers
  assign wrGated = wrEn_i & {NumLanes{~recover_i}};

  always_ff @(posedge clk) begin
    for (int w = 0; w < NumLanes; w++) begin
      if (wrGated[w]) begin
        regArray[wrTag_i[w]] <= wrData_i[w];  // Higher lane lands last
      end
    end
  end

endmodule

//--- verilog/operandLane.sv
// Operand lane with writeback bypass, branch squash and FU output register
`timescale 1ns/1ps

module operandLane (
  input  logic clk,
  input  logic rst_i,
  issueLaneIf.lane issue,
  input  logic [regReadPkg::DataW-1:0]                               rfData1_i,
  input  logic [regReadPkg::DataW-1:0]                               rfData2_i,
  input  logic [regReadPkg::NumLanes-1:0]                            wbValid_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0]   wbDest_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::DataW-1:0]      wbData_i,
  input  logic                                                       mispredict_i,
  input  logic [regReadPkg::CkptIdW-1:0]                             mispredictId_i,
  output logic                                                       fuValid_o,
  output logic [regReadPkg::DataW-1:0]                               fuSrc1Data_o,
  output logic [regReadPkg::DataW-1:0]                               fuSrc2Data_o,
  output logic [regReadPkg::PayloadW-1:0]                            fuPayload_o
);
  import regReadPkg::*;

  logic [DataW-1:0] src1Data;
  logic [DataW-1:0] src2Data;
  logic             squash;
  logic             validNext;

  // Pick the newest value of one source tag
  function automatic logic [DataW-1:0] bypassSel(
    input logic [PhysTagW-1:0]                tag,
    input logic [DataW-1:0]                   rfData,
    input logic [NumLanes-1:0]                wbValid,
    input logic [NumLanes-1:0][PhysTagW-1:0]  wbDest,
    input logic [NumLanes-1:0][DataW-1:0]     wbData
  );
    logic [DataW-1:0] sel;
    sel = rfData;
    for (int w = 0; w < NumLanes; w++) begin
      if (wbValid[w] && (wbDest[w] == tag)) begin
        sel = wbData[w];  // Highest lane wins
      end
    end
    return sel;
  endfunction

  // ******************************
  // Operand select
  // ******************************

  always_comb begin
    src1Data = bypassSel(issue.src1Tag, rfData1_i, wbValid_i, wbDest_i, wbData_i);
    src2Data = bypassSel(issue.src2Tag, rfData2_i, wbValid_i, wbDest_i, wbData_i);
  end

  // Drop work that sits under the mispredicted branch
  assign squash    = mispredict_i && issue.ckptMask[mispredictId_i];
  assign validNext = issue.valid && !squash;

  // ******************************
  // FU output register
  // ******************************

  always_ff @(posedge clk) begin
    if (rst_i) begin
      fuValid_o <= 1'b0;
    end else begin
      fuValid_o <= validNext;
    end
  end

  always_ff @(posedge clk) begin
    fuSrc1Data_o <= src1Data;
    fuSrc2Data_o <= src2Data;
    fuPayload_o  <= issue.payload;
  end

endmodule

//--- verilog/readyBitTable.sv
// Physical-register ready table with unmap clear, wakeup set and exception restore
`timescale 1ns/1ps

module readyBitTable (
  input  logic clk,
  input  logic rst_i,
  input  logic exception_i,
  input  logic [regReadPkg::NumLanes-1:0]                          unmapValid_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] unmapTag_i,
  input  logic [regReadPkg::NumLanes-1:0]                          wakeupValid_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] wakeupTag_i,
  output logic [regReadPkg::PhysRegs-1:0]                          phyRegRdy_o
);
  import regReadPkg::*;

  logic [PhysRegs-1:0] readyBits;
  logic [PhysRegs-1:0] readyNext;

  // Clears first so a wakeup on the same tag survives
  always_comb begin
    readyNext = readyBits;
    for (int u = 0; u < NumLanes; u++) begin
      if (unmapValid_i[u]) begin
        readyNext[unmapTag_i[u]] = 1'b0;
      end
    end
    for (int k = 0; k < NumLanes; k++) begin
      if (wakeupValid_i[k]) begin
        readyNext[wakeupTag_i[k]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || exception_i) begin
      readyBits <= ReadyInit;  // Back to the architectural mapping
    end else begin
      readyBits <= readyNext;
    end
  end

  assign phyRegRdy_o = readyBits;

endmodule

//--- verilog/regReadTop.sv
// Register-read stage top joining register file, operand lanes and ready table
`timescale 1ns/1ps

module regReadTop (
  input  logic clk,
  input  logic rst_i,

  // Issue side
  input  logic [regReadPkg::NumLanes-1:0]                          issueValid_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] src1Tag_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] src2Tag_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::NumCkpts-1:0] ckptMask_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PayloadW-1:0] payload_i,

  // Writeback buses
  input  logic [regReadPkg::NumLanes-1:0]                          wbValid_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] wbDest_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::DataW-1:0]    wbData_i,

  // Control
  input  logic                                                     mispredict_i,
  input  logic [regReadPkg::CkptIdW-1:0]                           mispredictId_i,
  input  logic                                                     recover_i,
  input  logic                                                     exception_i,

  // Ready table updates
  input  logic [regReadPkg::NumLanes-1:0]                          unmapValid_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] unmapTag_i,
  input  logic [regReadPkg::NumLanes-1:0]                          wakeupValid_i,
  input  logic [regReadPkg::NumLanes-1:0][regReadPkg::PhysTagW-1:0] wakeupTag_i,

  // Towards the functional units
  output logic [regReadPkg::NumLanes-1:0]                          fuValid_o,
  output logic [regReadPkg::NumLanes-1:0][regReadPkg::DataW-1:0]    fuSrc1Data_o,
  output logic [regReadPkg::NumLanes-1:0][regReadPkg::DataW-1:0]    fuSrc2Data_o,
  output logic [regReadPkg::NumLanes-1:0][regReadPkg::PayloadW-1:0] fuPayload_o,
  output logic [regReadPkg::PhysRegs-1:0]                          phyRegRdy_o
);
  import regReadPkg::*;

  logic [2*NumLanes-1:0][PhysTagW-1:0] rdTag;   // Two source tags per lane
  logic [2*NumLanes-1:0][DataW-1:0]    rdData;

  // ******************************
  // Register file
  // ******************************

  physRegFile rfU (
    .clk       (clk),
    .recover_i (recover_i),
    .rdTag_i   (rdTag),
    .rdData_o  (rdData),
    .wrEn_i    (wbValid_i),
    .wrTag_i   (wbDest_i),
    .wrData_i  (wbData_i)
  );

  // ******************************
  // Issue lanes
  // ******************************

  for (genvar g = 0; g < NumLanes; g++) begin : gLane
    issueLaneIf laneIf ();

    assign laneIf.valid    = issueValid_i[g];
    assign laneIf.src1Tag  = src1Tag_i[g];
    assign laneIf.src2Tag  = src2Tag_i[g];
    assign laneIf.ckptMask = ckptMask_i[g];
    assign laneIf.payload  = payload_i[g];

    assign rdTag[2*g]   = laneIf.src1Tag;
    assign rdTag[2*g+1] = laneIf.src2Tag;

    operandLane laneU (
      .clk            (clk),
      .rst_i          (rst_i),
      .issue          (laneIf.lane),
      .rfData1_i      (rdData[2*g]),
      .rfData2_i      (rdData[2*g+1]),
      .wbValid_i      (wbValid_i),
      .wbDest_i       (wbDest_i),
      .wbData_i       (wbData_i),
      .mispredict_i   (mispredict_i),
      .mispredictId_i (mispredictId_i),
      .fuValid_o      (fuValid_o[g]),
      .fuSrc1Data_o   (fuSrc1Data_o[g]),
      .fuSrc2Data_o   (fuSrc2Data_o[g]),
      .fuPayload_o    (fuPayload_o[g])
    );
  end

  // ******************************
  // Ready table
  // ******************************

  readyBitTable rdyU (
    .clk           (clk),
    .rst_i         (rst_i),
    .exception_i   (exception_i),
    .unmapValid_i  (unmapValid_i),
    .unmapTag_i    (unmapTag_i),
    .wakeupValid_i (wakeupValid_i),
    .wakeupTag_i   (wakeupTag_i),
    .phyRegRdy_o   (phyRegRdy_o)
  );

endmodule

//--- sim/regReadTb.sv
// Register-read stage testbench with shadow register file, shadow ready table and watchdog
`timescale 1ns/1ps

module regReadTb;
  import regReadPkg::*;

  localparam int ClkPeriod    = 40;
  localparam int ResetCycles  = 3;
  localparam int FillCycles   = PhysRegs / NumLanes + 1;
  localparam int WideCycles   = 200;
  localparam int NarrowCycles = 200;
  localparam int DrainCycles  = 4;
  localparam int TotalCycles  = ResetCycles + FillCycles + WideCycles + NarrowCycles
                                + DrainCycles + 2;

  // Only registers below ArchRegs ready
  localparam logic [PhysRegs-1:0] ReadyReset = PhysRegs'((64'd1 << ArchRegs) - 64'd1);

  logic clk = 1'b0;
  logic rst_i;
  logic [NumLanes-1:0]                issueValid_i;
  logic [NumLanes-1:0][PhysTagW-1:0]  src1Tag_i;
  logic [NumLanes-1:0][PhysTagW-1:0]  src2Tag_i;
  logic [NumLanes-1:0][NumCkpts-1:0]  ckptMask_i;
  logic [NumLanes-1:0][PayloadW-1:0]  payload_i;
  logic [NumLanes-1:0]                wbValid_i;
  logic [NumLanes-1:0][PhysTagW-1:0]  wbDest_i;
  logic [NumLanes-1:0][DataW-1:0]     wbData_i;
  logic                               mispredict_i;
  logic [CkptIdW-1:0]                 mispredictId_i;
  logic                               recover_i;
  logic                               exception_i;
  logic [NumLanes-1:0]                unmapValid_i;
  logic [NumLanes-1:0][PhysTagW-1:0]  unmapTag_i;
  logic [NumLanes-1:0]                wakeupValid_i;
  logic [NumLanes-1:0][PhysTagW-1:0]  wakeupTag_i;
  logic [NumLanes-1:0]                fuValid_o;
  logic [NumLanes-1:0][DataW-1:0]     fuSrc1Data_o;
  logic [NumLanes-1:0][DataW-1:0]     fuSrc2Data_o;
  logic [NumLanes-1:0][PayloadW-1:0]  fuPayload_o;
  logic [PhysRegs-1:0]                phyRegRdy_o;

  logic [15:0]                        lfsr = 16'd63037;
  logic [DataW-1:0]                   shadowRf [PhysRegs];
  logic [NumLanes-1:0]                expValid;
  logic [NumLanes-1:0][DataW-1:0]     expSrc1;
  logic [NumLanes-1:0][DataW-1:0]     expSrc2;
  logic [NumLanes-1:0][PayloadW-1:0]  expPayload;
  logic [PhysRegs-1:0]                expReady;
  logic                               hitSet;
  logic                               hitClr;

  regReadTop dut_i (.*);

  always #(ClkPeriod / 2) clk = ~clk;

  // Taps x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic reportFail(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first failing check");
  endtask

  // ******************************
  // Reference model
  // ******************************

  // Lane 1 writeback beats lane 0 which beats the file
  function automatic logic [DataW-1:0] expectOperand(input logic [PhysTagW-1:0] tag);
    if (wbValid_i[1] && wbDest_i[1] == tag) return wbData_i[1];
    if (wbValid_i[0] && wbDest_i[0] == tag) return wbData_i[0];
    return shadowRf[tag];
  endfunction

  always @(posedge clk) begin
    for (int l = 0; l < NumLanes; l++) begin
      expSrc1[l]    <= expectOperand(src1Tag_i[l]);
      expSrc2[l]    <= expectOperand(src2Tag_i[l]);
      expPayload[l] <= payload_i[l];
      expValid[l]   <= !rst_i && issueValid_i[l]
                       && !(mispredict_i && ckptMask_i[l][mispredictId_i]);
    end
    for (int w = 0; w < NumLanes; w++) begin
      if (wbValid_i[w] && !recover_i) shadowRf[wbDest_i[w]] <= wbData_i[w];
    end
    if (rst_i || exception_i) begin
      expReady <= ReadyReset;
    end else begin
      for (int r = 0; r < PhysRegs; r++) begin
        hitSet = 1'b0;
        hitClr = 1'b0;
        for (int l = 0; l < NumLanes; l++) begin
          if (wakeupValid_i[l] && wakeupTag_i[l] == PhysTagW'(r)) hitSet = 1'b1;
          if (unmapValid_i[l] && unmapTag_i[l] == PhysTagW'(r)) hitClr = 1'b1;
        end
        if (hitSet) expReady[r] <= 1'b1;  // Set beats clear
        else if (hitClr) expReady[r] <= 1'b0;
      end
    end
  end

  // ******************************
  // Output checks
  // ******************************

  validCheck: assert property (@(posedge clk) disable iff (rst_i) fuValid_o === expValid)
    else reportFail($sformatf("fuValid_o %b expected %b", $sampled(fuValid_o),
                              $sampled(expValid)));

  readyCheck: assert property (@(posedge clk) disable iff (rst_i) phyRegRdy_o === expReady)
    else reportFail($sformatf("phyRegRdy_o %h expected %h", $sampled(phyRegRdy_o),
                              $sampled(expReady)));

  for (genvar g = 0; g < NumLanes; g++) begin : gCheck
    dataCheck: assert property (@(posedge clk) disable iff (rst_i)
        expValid[g] |-> (fuSrc1Data_o[g] === expSrc1[g] && fuSrc2Data_o[g] === expSrc2[g]
                         && fuPayload_o[g] === expPayload[g]))
      else reportFail($sformatf("lane %0d src1 %h/%h src2 %h/%h payload %h/%h", g,
                                $sampled(fuSrc1Data_o[g]), $sampled(expSrc1[g]),
                                $sampled(fuSrc2Data_o[g]), $sampled(expSrc2[g]),
                                $sampled(fuPayload_o[g]), $sampled(expPayload[g])));
  end

  // ******************************
  // Stimulus
  // ******************************

  task automatic idleInputs();
    issueValid_i   = '0;
    src1Tag_i      = '0;
    src2Tag_i      = '0;
    ckptMask_i     = '0;
    payload_i      = '0;
    wbValid_i      = '0;
    wbDest_i       = '0;
    wbData_i       = '0;
    mispredict_i   = 1'b0;
    mispredictId_i = '0;
    recover_i      = 1'b0;
    exception_i    = 1'b0;
    unmapValid_i   = '0;
    unmapTag_i     = '0;
    wakeupValid_i  = '0;
    wakeupTag_i    = '0;
  endtask

  // Write every physical register once so reads are known
  task automatic fillRegFile();
    for (int c = 0; c < PhysRegs / NumLanes; c++) begin
      @(negedge clk);
      for (int l = 0; l < NumLanes; l++) begin
        wbValid_i[l] = 1'b1;
        wbDest_i[l]  = PhysTagW'(NumLanes * c + l);
        wbData_i[l]  = DataW'(randBits(DataW));
      end
    end
    @(negedge clk);
    wbValid_i = '0;
  endtask

  // Narrow tagW makes tag collisions common
  task automatic driveCycle(input int tagW, input bit ctrlOn);
    @(negedge clk);
    for (int l = 0; l < NumLanes; l++) begin
      issueValid_i[l]  = 1'(randBits(1));
      src1Tag_i[l]     = PhysTagW'(randBits(tagW));
      src2Tag_i[l]     = PhysTagW'(randBits(tagW));
      ckptMask_i[l]    = NumCkpts'(randBits(NumCkpts));
      payload_i[l]     = PayloadW'(randBits(PayloadW));
      wbValid_i[l]     = 1'(randBits(1));
      wbDest_i[l]      = PhysTagW'(randBits(tagW));
      wbData_i[l]      = DataW'(randBits(DataW));
      unmapValid_i[l]  = 1'(randBits(1));
      unmapTag_i[l]    = PhysTagW'(randBits(tagW));
      wakeupValid_i[l] = 1'(randBits(1));
      wakeupTag_i[l]   = PhysTagW'(randBits(tagW));
    end
    mispredict_i   = ctrlOn && (randBits(1) == 32'd1);
    mispredictId_i = CkptIdW'(randBits(CkptIdW));
    recover_i      = ctrlOn && (randBits(2) == 32'd0);
    exception_i    = ctrlOn && (randBits(4) == 32'd0);
  endtask

  initial begin
    rst_i = 1'b1;
    idleInputs();
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    resetCheck: assert (fuValid_o === '0 && phyRegRdy_o === ReadyReset)
      else reportFail($sformatf("after reset fuValid_o %b phyRegRdy_o %h", fuValid_o,
                                phyRegRdy_o));
    fillRegFile();
    repeat (WideCycles) driveCycle(PhysTagW, 1'b0);
    repeat (NarrowCycles) driveCycle(2, 1'b1);
    @(negedge clk);
    idleInputs();
    repeat (DrainCycles) @(negedge clk);
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #((TotalCycles + 50) * ClkPeriod);
    $display("Timeout: the run went past the expected number of cycles");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- filelist.f
verilog/regReadPkg.sv
verilog/issueLaneIf.sv
verilog/physRegFile.sv
verilog/operandLane.sv
verilog/readyBitTable.sv
verilog/regReadTop.sv
sim/regReadTb.sv

//--- Bender.yml
package:
  name: reg_read_stage

sources:
  - verilog/regReadPkg.sv
  - verilog/issueLaneIf.sv
  - verilog/physRegFile.sv
  - verilog/operandLane.sv
  - verilog/readyBitTable.sv
  - verilog/regReadTop.sv
  - target: simulation
    files:
      - sim/regReadTb.sv
